// ==== rtl/beam_defines.svh ====
`ifndef BEAM_DEFINES_SVH
`define BEAM_DEFINES_SVH

// Width of one I or Q component at the input and at the output.
`define BF_SAMPLE_WIDTH 15

// Signed weight coefficient width.
// Five bits covers the -16..15 range used by the steering tables.
`define BF_WEIGHT_WIDTH 5

// Antenna channels summed by the combiner.
`define BF_CHANNELS 2

`endif

// ==== rtl/sample_pkg.sv ====
`include "beam_defines.svh"
`default_nettype none

// Sample-path types, from the input sample through to the clip counter.
package sample_pkg;

	// One I or Q component.
	typedef logic signed [`BF_SAMPLE_WIDTH-1:0] sample_t;

	// Complex sample, i in the upper half.
	typedef struct packed {
		sample_t i;
		sample_t q;
	} iq_sample_t;

	// Full-precision sample times weight.
	typedef logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH-1:0] product_t;

	// Sum of two products, one guard bit.
	typedef logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH:0] rotated_t;

	// Channel sum, grows with the channel count.
	typedef logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH+$clog2(`BF_CHANNELS):0] sum_t;

	typedef logic [15:0] clip_count_t; // Saturating counter.

endpackage

`default_nettype wire

// ==== rtl/weight_pkg.sv ====
`include "beam_defines.svh"
`default_nettype none

// Beam weight types.
package weight_pkg;

	typedef logic signed [`BF_WEIGHT_WIDTH-1:0] weight_t;

	// Complex weight for one channel.
	typedef struct packed {
		weight_t cos;
		weight_t sin;
	} weight_pair_t;

	// Index of the channel being written.
	typedef logic [$clog2(`BF_CHANNELS)-1:0] channel_t;

	// One pair per channel, channel 0 in the low bits.
	typedef weight_pair_t [`BF_CHANNELS-1:0] weight_set_t;

endpackage

`default_nettype wire

// ==== rtl/weight_set_if.sv ====
`include "beam_defines.svh"
`default_nettype none

// Active weight set, fanned out from the bank to every rotator.
interface weight_set_if;

	weight_pkg::weight_set_t set;

	// Per-channel view, so a rotator only picks its own pair.
	function automatic weight_pkg::weight_pair_t channel_pair(input int channel);
		return set[channel];
	endfunction

	modport source (
		output set
	);

	modport sink (
		input set,
		import channel_pair
	);

endinterface

`default_nettype wire

// ==== rtl/weight_bank.sv ====
`include "beam_defines.svh"
`default_nettype none

// Double-buffered beam weights.
// Writes land in the shadow set one channel at a time, and a commit
// moves the whole shadow set to the active set in one edge, so the
// rotators never see a half-updated beam.
module weight_bank (
	input wire logic clock,
	input wire logic reset,
	input wire logic weight_write,
	input wire weight_pkg::channel_t weight_channel,
	input wire weight_pkg::weight_t weight_cos,
	input wire weight_pkg::weight_t weight_sin,
	input wire logic weight_commit,
	weight_set_if.source weights
);

	weight_pkg::weight_set_t shadow;
	weight_pkg::weight_set_t active;

	// One shadow pair per write strobe.
	always_ff @(posedge clock) begin
		if (reset) begin
			shadow <= '0;
		end else if (weight_write) begin
			shadow[weight_channel].cos <= weight_cos;
			shadow[weight_channel].sin <= weight_sin;
		end
	end

	// A commit copies the shadow set as it stood before this edge,
	// so a write in the same cycle waits for the next commit.
	always_ff @(posedge clock) begin
		if (reset) begin
			active <= '0;
		end else if (weight_commit) begin
			active <= shadow;
		end
	end

	assign weights.set = active;

	// Channel index from the host must name a real channel.
	assert property (@(posedge clock) disable iff (reset)
		weight_write |-> (weight_channel < `BF_CHANNELS))
		else $error("weight_bank: write to channel %0d out of range", weight_channel);

endmodule

`default_nettype wire

// ==== rtl/phase_rotator.sv ====
`include "beam_defines.svh"
`default_nettype none

// Complex weight multiply for one antenna channel.
// Stage 1 registers the four partial products, stage 2 combines them:
//   rot_i = I*cos + Q*sin
//   rot_q = Q*cos - I*sin
module phase_rotator #(
	parameter int CHANNEL = 0
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic in_valid,
	input wire sample_pkg::iq_sample_t in_sample,
	weight_set_if.sink weights,
	output logic rot_valid,
	output sample_pkg::rotated_t rot_i,
	output sample_pkg::rotated_t rot_q
);

	weight_pkg::weight_pair_t pair;

	sample_pkg::product_t prod_ic; // I * cos.
	sample_pkg::product_t prod_is; // I * sin.
	sample_pkg::product_t prod_qc; // Q * cos.
	sample_pkg::product_t prod_qs; // Q * sin.

	logic valid_s1;

	// Weights are taken in the cycle the sample arrives.
	assign pair = weights.channel_pair(CHANNEL);

	// Stage 1 partial products.
	always_ff @(posedge clock) begin
		if (in_valid) begin
			prod_ic <= in_sample.i * pair.cos;
			prod_is <= in_sample.i * pair.sin;
			prod_qc <= in_sample.q * pair.cos;
			prod_qs <= in_sample.q * pair.sin;
		end
	end

	// Stage 2 rotated components.
	always_ff @(posedge clock) begin
		if (valid_s1) begin
			rot_i <= prod_ic + prod_qs;
			rot_q <= prod_qc - prod_is;
		end
	end

	// Valid bit moves alongside the data.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_s1 <= 1'b0;
			rot_valid <= 1'b0;
		end else begin
			valid_s1 <= in_valid;
			rot_valid <= valid_s1;
		end
	end

	// Fixed two-cycle latency through the rotator.
	assert property (@(posedge clock) disable iff (reset)
		in_valid |-> ##2 rot_valid)
		else $error("phase_rotator %0d: rot_valid missing two cycles after in_valid",
			CHANNEL);

endmodule

`default_nettype wire

// ==== rtl/beam_combiner.sv ====
`include "beam_defines.svh"
`default_nettype none

// Sums the rotated channels, saturates to the output width and
// registers the result. Also counts output samples that clipped.
module beam_combiner (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`BF_CHANNELS-1:0] rot_valid,
	input wire sample_pkg::rotated_t rot_i [`BF_CHANNELS],
	input wire sample_pkg::rotated_t rot_q [`BF_CHANNELS],
	output logic out_valid,
	output sample_pkg::sample_t out_i,
	output sample_pkg::sample_t out_q,
	output sample_pkg::clip_count_t clip_count
);

	// Output range limits, in sum width for a signed compare.
	localparam sample_pkg::sum_t SAMPLE_MAX = (1 <<< (`BF_SAMPLE_WIDTH - 1)) - 1;
	localparam sample_pkg::sum_t SAMPLE_MIN = -(1 <<< (`BF_SAMPLE_WIDTH - 1));

	sample_pkg::sum_t sum_i;
	sample_pkg::sum_t sum_q;
	sample_pkg::sample_t sat_i;
	sample_pkg::sample_t sat_q;
	logic clip_i;
	logic clip_q;
	logic valid;

	// Clamp to full scale, otherwise keep the low bits.
	function automatic sample_pkg::sample_t saturate(input sample_pkg::sum_t value);
		if (value > SAMPLE_MAX)
			return {1'b0, {(`BF_SAMPLE_WIDTH - 1){1'b1}}};
		else if (value < SAMPLE_MIN)
			return {1'b1, {(`BF_SAMPLE_WIDTH - 1){1'b0}}};
		return value[`BF_SAMPLE_WIDTH-1:0];
	endfunction

	// Channel adder tree.
	always_comb begin
		sum_i = '0;
		sum_q = '0;
		for (int c = 0; c < `BF_CHANNELS; c++) begin
			sum_i += rot_i[c];
			sum_q += rot_q[c];
		end
	end

	assign sat_i = saturate(sum_i);
	assign sat_q = saturate(sum_q);
	assign clip_i = (sum_i > SAMPLE_MAX) || (sum_i < SAMPLE_MIN);
	assign clip_q = (sum_q > SAMPLE_MAX) || (sum_q < SAMPLE_MIN);

	assign valid = &rot_valid; // All channels in lock step.

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_i <= '0;
			out_q <= '0;
		end else begin
			out_valid <= valid;
			if (valid) begin // Hold between strobes.
				out_i <= sat_i;
				out_q <= sat_q;
			end
		end
	end

	// One count per clipped output sample, sticks at all ones.
	always_ff @(posedge clock) begin
		if (reset)
			clip_count <= '0;
		else if (valid && (clip_i || clip_q) && (clip_count != '1))
			clip_count <= clip_count + 1'b1;
	end

	// The rotators share one in_valid, so their valid bits must agree.
	assert property (@(posedge clock) disable iff (reset)
		(rot_valid == '0) || (&rot_valid))
		else $error("beam_combiner: channel valid bits disagree %b", rot_valid);

endmodule

`default_nettype wire

// ==== rtl/beam_former_top.sv ====
`include "beam_defines.svh"
`default_nettype none

// Two-channel receive beamformer.
// Latency from in_valid to out_valid is three cycles: two in the
// rotators and one in the combiner output register.
module beam_former_top (
	input wire logic clock,
	input wire logic reset,

	input wire logic in_valid,
	input wire sample_pkg::sample_t in_i_1,
	input wire sample_pkg::sample_t in_q_1,
	input wire sample_pkg::sample_t in_i_2,
	input wire sample_pkg::sample_t in_q_2,

	input wire logic weight_write,
	input wire weight_pkg::channel_t weight_channel,
	input wire weight_pkg::weight_t weight_cos,
	input wire weight_pkg::weight_t weight_sin,
	input wire logic weight_commit,

	output logic out_valid,
	output sample_pkg::sample_t out_i,
	output sample_pkg::sample_t out_q,
	output sample_pkg::clip_count_t clip_count
);

	weight_set_if weight_set ();

	logic [`BF_CHANNELS-1:0] rot_valid;
	sample_pkg::rotated_t rot_i [`BF_CHANNELS];
	sample_pkg::rotated_t rot_q [`BF_CHANNELS];

	weight_bank weight_bank_inst (
		.clock(clock),
		.reset(reset),
		.weight_write(weight_write),
		.weight_channel(weight_channel),
		.weight_cos(weight_cos),
		.weight_sin(weight_sin),
		.weight_commit(weight_commit),
		.weights(weight_set)
	);

	// Antenna 1 maps to channel 0.
	phase_rotator #(
		.CHANNEL(0)
	) phase_rotator_0_inst (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_sample({in_i_1, in_q_1}),
		.weights(weight_set),
		.rot_valid(rot_valid[0]),
		.rot_i(rot_i[0]),
		.rot_q(rot_q[0])
	);

	phase_rotator #(
		.CHANNEL(1)
	) phase_rotator_1_inst (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_sample({in_i_2, in_q_2}),
		.weights(weight_set),
		.rot_valid(rot_valid[1]),
		.rot_i(rot_i[1]),
		.rot_q(rot_q[1])
	);

	beam_combiner beam_combiner_inst (
		.clock(clock),
		.reset(reset),
		.rot_valid(rot_valid),
		.rot_i(rot_i),
		.rot_q(rot_q),
		.out_valid(out_valid),
		.out_i(out_i),
		.out_q(out_q),
		.clip_count(clip_count)
	);

endmodule

`default_nettype wire

// ==== test/beam_former_vectors.svh ====
// Directed vectors, one add_vector call per input sample.
// Columns: name, cos0, sin0, cos1, sin1, commit, i1, q1, i2, q2, out_i, out_q, clip.
// Weights that differ from the shadow set are written first, and commit makes them active.
task automatic load_directed_vectors();
	// Channel 0 alone, pure gain and then pure rotation.
	add_vector("ch0_cos15", 15, 0, 0, 0, 1'b1, 100, -200, 500, 700, 1500, -3000, 1'b0);
	add_vector("ch0_cos15_b2b", 15, 0, 0, 0, 1'b0, -1000, 1000, 3, 3, -15000, 15000, 1'b0);
	add_vector("ch0_sin15", 0, 15, 0, 0, 1'b1, 100, -200, 0, 0, -3000, -1500, 1'b0);

	// Mixed weights on both channels, back to back after the commit.
	add_vector("mixed_a", 7, -3, -5, 9, 1'b1, 100, 200, -150, 50, 1300, 2800, 1'b0);
	add_vector("mixed_b", 7, -3, -5, 9, 1'b0, -400, 300, 250, -600, -10350, 1650, 1'b0);
	add_vector("mixed_c", 7, -3, -5, 9, 1'b0, 1234, -567, -89, -1011, 1685, 5589, 1'b0);

	// Saturation at both ends, and a sum just inside full scale.
	add_vector("clip_pos", 15, 0, 15, 0, 1'b1, 16000, 0, 16000, 0, 16383, 0, 1'b1);
	add_vector("clip_neg", 15, 0, 15, 0, 1'b0, -16384, -16384, -16384, -16384,
		-16384, -16384, 1'b1);
	add_vector("clip_none", 15, 0, 15, 0, 1'b0, 1000, -1000, 92, 92, 16380, -13620, 1'b0);

	// New weights wait in the shadow set until the commit.
	add_vector("shadow_hold", -16, 1, 3, -2, 1'b0, 10, 20, 30, 40, 600, 900, 1'b0);
	add_vector("commit_new", -16, 1, 3, -2, 1'b1, 10, 20, 30, 40, -130, -150, 1'b0);
endtask

// ==== test/beam_former_tb.sv ====
`include "beam_defines.svh"
`default_nettype none

module beam_former_tb;

	typedef struct packed {
		weight_pkg::weight_set_t weights;
		logic commit;
		sample_pkg::iq_sample_t [`BF_CHANNELS-1:0] samples;
		sample_pkg::sample_t exp_i;
		sample_pkg::sample_t exp_q;
		logic clip;
	} vector_t;

	typedef struct packed {
		int index;
		int in_cycle; // Cycle in which in_valid was driven.
	} pending_t;

	localparam int full_scale = 1 << (`BF_SAMPLE_WIDTH - 1);

	logic clock;
	logic reset;
	logic in_valid;
	sample_pkg::sample_t in_i_1;
	sample_pkg::sample_t in_q_1;
	sample_pkg::sample_t in_i_2;
	sample_pkg::sample_t in_q_2;
	logic weight_write;
	weight_pkg::channel_t weight_channel;
	weight_pkg::weight_t weight_cos;
	weight_pkg::weight_t weight_sin;
	logic weight_commit;
	logic out_valid;
	sample_pkg::sample_t out_i;
	sample_pkg::sample_t out_q;
	sample_pkg::clip_count_t clip_count;

	vector_t vectors[$];
	string vector_names[$];
	pending_t pending[$];
	weight_pkg::weight_set_t shadow = '0; // Mirror of the DUT shadow registers.
	sample_pkg::clip_count_t expected_clips = '0;
	logic [31:0] lfsr = 32'hfffd;
	int cycle = 0;
	int cycle_limit = 0;

	beam_former_top beam_former_top_inst (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_i_1(in_i_1),
		.in_q_1(in_q_1),
		.in_i_2(in_i_2),
		.in_q_2(in_q_2),
		.weight_write(weight_write),
		.weight_channel(weight_channel),
		.weight_cos(weight_cos),
		.weight_sin(weight_sin),
		.weight_commit(weight_commit),
		.out_valid(out_valid),
		.out_i(out_i),
		.out_q(out_q),
		.clip_count(clip_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_sample(input string name, input sample_pkg::sample_t expected,
		input sample_pkg::sample_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic check_count(input string name, input sample_pkg::clip_count_t expected,
		input sample_pkg::clip_count_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic check_latency(input string name, input int in_cycle, input int out_cycle);
		if (out_cycle - in_cycle != 3)
			abort_run($sformatf("Fail %s latency: expected 3, actual %0d", name,
				out_cycle - in_cycle));
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken.
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int b = 0; b < width; b++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Rotate each channel, sum, then clamp to full scale.
	function automatic void apply_beam_rule(inout vector_t v);
		int acc_i;
		int acc_q;
		acc_i = 0;
		acc_q = 0;
		for (int c = 0; c < `BF_CHANNELS; c++) begin
			weight_pkg::weight_t wc;
			weight_pkg::weight_t ws;
			sample_pkg::sample_t si;
			sample_pkg::sample_t sq;
			wc = v.weights[c].cos;
			ws = v.weights[c].sin;
			si = v.samples[c].i;
			sq = v.samples[c].q;
			acc_i += int'(si) * int'(wc) + int'(sq) * int'(ws);
			acc_q += int'(sq) * int'(wc) - int'(si) * int'(ws);
		end
		v.clip = (acc_i >= full_scale) || (acc_i < -full_scale) ||
			(acc_q >= full_scale) || (acc_q < -full_scale);
		v.exp_i = (acc_i >= full_scale) ? full_scale - 1 :
			(acc_i < -full_scale) ? -full_scale : acc_i;
		v.exp_q = (acc_q >= full_scale) ? full_scale - 1 :
			(acc_q < -full_scale) ? -full_scale : acc_q;
	endfunction

	task automatic add_vector(input string name, input int cos0, sin0, cos1, sin1,
		input bit commit, input int i1, q1, i2, q2, exp_i, exp_q, input bit clip);
		vector_t v;
		v.weights[0].cos = weight_pkg::weight_t'(cos0);
		v.weights[0].sin = weight_pkg::weight_t'(sin0);
		v.weights[1].cos = weight_pkg::weight_t'(cos1);
		v.weights[1].sin = weight_pkg::weight_t'(sin1);
		v.commit = commit;
		v.samples[0].i = sample_pkg::sample_t'(i1);
		v.samples[0].q = sample_pkg::sample_t'(q1);
		v.samples[1].i = sample_pkg::sample_t'(i2);
		v.samples[1].q = sample_pkg::sample_t'(q2);
		v.exp_i = sample_pkg::sample_t'(exp_i);
		v.exp_q = sample_pkg::sample_t'(exp_q);
		v.clip = clip;
		vectors.push_back(v);
		vector_names.push_back(name);
	endtask

	`include "beam_former_vectors.svh"

	// Each group commits one random beam and then streams samples through it.
	task automatic add_random_vectors(input int groups, input int per_group);
		vector_t v;
		for (int g = 0; g < groups; g++) begin
			for (int c = 0; c < `BF_CHANNELS; c++) begin
				v.weights[c].cos = weight_pkg::weight_t'(random_bits(`BF_WEIGHT_WIDTH));
				v.weights[c].sin = weight_pkg::weight_t'(random_bits(`BF_WEIGHT_WIDTH));
			end
			for (int k = 0; k < per_group; k++) begin
				v.commit = (k == 0);
				for (int c = 0; c < `BF_CHANNELS; c++) begin
					v.samples[c].i = sample_pkg::sample_t'(random_bits(`BF_SAMPLE_WIDTH));
					v.samples[c].q = sample_pkg::sample_t'(random_bits(`BF_SAMPLE_WIDTH));
				end
				apply_beam_rule(v);
				vectors.push_back(v);
				vector_names.push_back($sformatf("random_%0d_%0d", g, k));
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
		in_valid = 1'b0;
		weight_write = 1'b0;
		weight_commit = 1'b0;
	endtask

	task automatic apply_vector(input int index);
		vector_t v;
		v = vectors[index];
		for (int c = 0; c < `BF_CHANNELS; c++) begin
			if (v.weights[c] != shadow[c]) begin
				next_cycle();
				weight_write = 1'b1;
				weight_channel = weight_pkg::channel_t'(c);
				weight_cos = v.weights[c].cos;
				weight_sin = v.weights[c].sin;
				shadow[c] = v.weights[c];
			end
		end
		if (v.commit) begin
			next_cycle();
			weight_commit = 1'b1;
		end
		next_cycle();
		in_valid = 1'b1;
		in_i_1 = v.samples[0].i;
		in_q_1 = v.samples[0].q;
		in_i_2 = v.samples[1].i;
		in_q_2 = v.samples[1].q;
		pending.push_back(pending_t'{index: index, in_cycle: cycle});
	endtask

	task automatic score_output();
		pending_t p;
		vector_t v;
		p = pending.pop_front();
		v = vectors[p.index];
		check_latency(vector_names[p.index], p.in_cycle, cycle);
		check_sample({vector_names[p.index], " out_i"}, v.exp_i, out_i);
		check_sample({vector_names[p.index], " out_q"}, v.exp_q, out_q);
		if (v.clip && expected_clips != '1)
			expected_clips++;
		check_count({vector_names[p.index], " clip_count"}, expected_clips, clip_count);
	endtask

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle_limit > 0 && cycle >= cycle_limit)
			abort_run($sformatf("Timeout: no end of test after %0d cycles.", cycle_limit));
	end

	// Outputs are read mid-cycle away from the driving edge.
	always @(negedge clock) begin
		if (!reset && out_valid) begin
			if (pending.size() == 0)
				abort_run("out_valid went high with no sample in flight.");
			else
				score_output();
		end
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_i_1 = '0;
		in_q_1 = '0;
		in_i_2 = '0;
		in_q_2 = '0;
		weight_write = 1'b0;
		weight_channel = '0;
		weight_cos = '0;
		weight_sin = '0;
		weight_commit = 1'b0;

		load_directed_vectors();
		add_random_vectors(4, 4);
		cycle_limit = vectors.size() * 4 + 64;

		repeat (16) @(posedge clock);
		#1 reset = 1'b0;

		// Idle outputs right after reset.
		repeat (4) @(negedge clock);
		check_sample("reset out_i", '0, out_i);
		check_sample("reset out_q", '0, out_q);
		check_count("reset clip_count", '0, clip_count);

		for (int n = 0; n < vectors.size(); n++)
			apply_vector(n);
		next_cycle();
		while (pending.size() != 0)
			next_cycle();

		// Last result stays on the outputs once the strobes stop.
		repeat (2) @(negedge clock);
		check_sample("hold out_i", vectors[vectors.size() - 1].exp_i, out_i);
		check_sample("hold out_q", vectors[vectors.size() - 1].exp_q, out_q);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
+incdir+test
rtl/sample_pkg.sv
rtl/weight_pkg.sv
rtl/weight_set_if.sv
rtl/weight_bank.sv
rtl/phase_rotator.sv
rtl/beam_combiner.sv
rtl/beam_former_top.sv
test/beam_former_tb.sv
